//--- src/lc3b_settings.svh
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// Datapath and address width
`define LC3B_WORD_W 16

`define LC3B_REG_W 3
`define LC3B_NUM_REGS 8

`define LC3B_RESET_PC 16'h0000 // First fetch address

`endif

//--- src/lc3b_pkg.sv
`include "lc3b_settings.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

    // Full ISA encoding of which only part is executed
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass // Passes the B operand
    } lc3b_aluop;

    // Source of the ALU B operand
    typedef enum logic [1:0] {
        bsel_reg,
        bsel_imm4,
        bsel_imm5,
        bsel_off6
    } lc3b_bsel;

    typedef struct packed {
        lc3b_aluop aluop;
        lc3b_bsel  bsel;
        logic      load_regfile;
        logic      d_mem_read;
        logic      d_mem_write;
    } lc3b_ctrl;

    typedef struct packed {
        lc3b_ctrl    ctrl;
        lc3b_reg     dest;
        lc3b_reg     src1;
        lc3b_reg     src2;      // Holds the store source for STR
        lc3b_word    src1_data;
        lc3b_word    src2_data;
        logic [10:0] imm;       // ir[10:0]
    } id_ex_t;

    typedef struct packed {
        logic     load_regfile;
        logic     d_mem_read;
        logic     d_mem_write;
        lc3b_reg  dest;
        lc3b_word alu_result;   // Also the data address
        lc3b_word store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     load_regfile;
        lc3b_reg  dest;
        lc3b_word result;
    } mem_wb_t;

endpackage

//--- src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg import lc3b_pkg::*; #(
    parameter type T = lc3b_word
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_valid,
    input  T     i_data,
    output logic o_valid,
    output T     o_data
);

    // No stall in this pipeline, so the register loads every cycle
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            o_valid <= i_valid;
            o_data  <= i_data;
        end
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module fetch_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  lc3b_word i_imem_rdata,
    output lc3b_word o_imem_addr,
    output logic     o_imem_read,
    output lc3b_word o_ir,
    output logic     o_ir_valid
);

    lc3b_word pc;
    lc3b_word pc_plus2;
    logic     fetch_en;

    assign pc_plus2 = pc + lc3b_word'(2);
    assign fetch_en = ~i_rst; // Fetching whenever out of reset

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= `LC3B_RESET_PC;
        end else begin
            pc <= pc_plus2;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ir_valid <= 1'b0;
            o_ir       <= '0;
        end else begin
            o_ir_valid <= fetch_en;
            o_ir       <= i_imem_rdata; // Memory answers in the same cycle
        end
    end

    assign o_imem_addr = pc;
    assign o_imem_read = fetch_en;

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module regfile import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_we,
    input  lc3b_reg  i_dest,
    input  lc3b_word i_wdata,
    input  lc3b_reg  i_src_a,
    input  lc3b_reg  i_src_b,
    output lc3b_word o_reg_a,
    output lc3b_word o_reg_b
);

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_dest] <= i_wdata;
        end
    end

    // Writeback in the same cycle wins over the stored value
    assign o_reg_a = (i_we && i_dest == i_src_a) ? i_wdata : regs[i_src_a];
    assign o_reg_b = (i_we && i_dest == i_src_b) ? i_wdata : regs[i_src_b];

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  lc3b_word i_ir,
    input  logic     i_ir_valid,
    input  logic     i_wb_we,
    input  lc3b_reg  i_wb_dest,
    input  lc3b_word i_wb_data,
    output id_ex_t   o_id_ex,
    output logic     o_id_ex_valid
);

    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    src1;
    lc3b_reg    src2_sel;
    lc3b_word   src1_data;
    lc3b_word   src2_data;
    lc3b_ctrl   ctrl;
    logic       read_dest;  // STR reads its source through port B
    id_ex_t     id_ex_d;

    assign opcode   = lc3b_opcode'(i_ir[15:12]);
    assign dest     = i_ir[11:9];
    assign src1     = i_ir[8:6];
    assign src2_sel = read_dest ? dest : i_ir[2:0];

    always_comb begin
        ctrl.aluop        = alu_pass;
        ctrl.bsel         = bsel_reg;
        ctrl.load_regfile = 1'b0;
        ctrl.d_mem_read   = 1'b0;
        ctrl.d_mem_write  = 1'b0;
        read_dest         = 1'b0;
        if (i_ir_valid) begin
            case (opcode)
                op_add, op_and: begin
                    ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
                    ctrl.bsel         = i_ir[5] ? bsel_imm5 : bsel_reg;
                    ctrl.load_regfile = 1'b1;
                end
                op_not: begin
                    ctrl.aluop        = alu_not;
                    ctrl.load_regfile = 1'b1;
                end
                op_shf: begin
                    // ir[4] picks direction, ir[5] arithmetic
                    if (!i_ir[4]) begin
                        ctrl.aluop = alu_sll;
                    end else begin
                        ctrl.aluop = i_ir[5] ? alu_sra : alu_srl;
                    end
                    ctrl.bsel         = bsel_imm4;
                    ctrl.load_regfile = 1'b1;
                end
                op_ldr: begin
                    ctrl.aluop        = alu_add; // Base plus offset
                    ctrl.bsel         = bsel_off6;
                    ctrl.load_regfile = 1'b1;
                    ctrl.d_mem_read   = 1'b1;
                end
                op_str: begin
                    ctrl.aluop       = alu_add;
                    ctrl.bsel        = bsel_off6;
                    ctrl.d_mem_write = 1'b1;
                    read_dest        = 1'b1;
                end
                default: ; // Bubble
            endcase
        end
    end

    regfile u_regfile (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_we    (i_wb_we),
        .i_dest  (i_wb_dest),
        .i_wdata (i_wb_data),
        .i_src_a (src1),
        .i_src_b (src2_sel),
        .o_reg_a (src1_data),
        .o_reg_b (src2_data)
    );

    always_comb begin
        id_ex_d.ctrl      = ctrl;
        id_ex_d.dest      = dest;
        id_ex_d.src1      = src1;
        id_ex_d.src2      = src2_sel;
        id_ex_d.src1_data = src1_data;
        id_ex_d.src2_data = src2_data;
        id_ex_d.imm       = i_ir[10:0];
    end

    stage_reg #(.T(id_ex_t)) u_id_ex (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (i_ir_valid),
        .i_data  (id_ex_d),
        .o_valid (o_id_ex_valid),
        .o_data  (o_id_ex)
    );

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module execute_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  id_ex_t   i_id_ex,
    input  logic     i_id_ex_valid,
    input  logic     i_mem_we,
    input  lc3b_reg  i_mem_dest,
    input  lc3b_word i_mem_result,
    input  logic     i_wb_we,
    input  lc3b_reg  i_wb_dest,
    input  lc3b_word i_wb_data,
    output ex_mem_t  o_ex_mem,
    output logic     o_ex_mem_valid
);

    lc3b_word    fwd_a;
    lc3b_word    fwd_b;
    lc3b_word    op_b;
    lc3b_word    alu_out;
    logic [10:0] imm;
    ex_mem_t     ex_mem_d;

    assign imm = i_id_ex.imm;

    // Memory stage result is newer, so it is checked first
    function automatic lc3b_word fwd_sel(input lc3b_reg src, input lc3b_word reg_data);
        if (i_mem_we && i_mem_dest == src) begin
            return i_mem_result;
        end else if (i_wb_we && i_wb_dest == src) begin
            return i_wb_data;
        end
        return reg_data;
    endfunction

    always_comb begin
        fwd_a = fwd_sel(i_id_ex.src1, i_id_ex.src1_data);
        fwd_b = fwd_sel(i_id_ex.src2, i_id_ex.src2_data);
    end

    always_comb begin
        case (i_id_ex.ctrl.bsel)
            bsel_imm4: op_b = lc3b_word'(imm[3:0]);
            bsel_imm5: op_b = {{(`LC3B_WORD_W-5){imm[4]}}, imm[4:0]};
            bsel_off6: op_b = {{(`LC3B_WORD_W-7){imm[5]}}, imm[5:0], 1'b0}; // Word offset
            default:   op_b = fwd_b;
        endcase
    end

    always_comb begin
        case (i_id_ex.ctrl.aluop)
            alu_add: alu_out = fwd_a + op_b;
            alu_and: alu_out = fwd_a & op_b;
            alu_not: alu_out = ~fwd_a;
            alu_sll: alu_out = fwd_a << op_b[3:0];
            alu_srl: alu_out = fwd_a >> op_b[3:0];
            alu_sra: alu_out = lc3b_word'($signed(fwd_a) >>> op_b[3:0]);
            default: alu_out = op_b;
        endcase
    end

    always_comb begin
        ex_mem_d.load_regfile = i_id_ex.ctrl.load_regfile;
        ex_mem_d.d_mem_read   = i_id_ex.ctrl.d_mem_read;
        ex_mem_d.d_mem_write  = i_id_ex.ctrl.d_mem_write;
        ex_mem_d.dest         = i_id_ex.dest;
        ex_mem_d.alu_result   = alu_out;
        ex_mem_d.store_data   = fwd_b; // STR source after forwarding
    end

    stage_reg #(.T(ex_mem_t)) u_ex_mem (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (i_id_ex_valid),
        .i_data  (ex_mem_d),
        .o_valid (o_ex_mem_valid),
        .o_data  (o_ex_mem)
    );

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  ex_mem_t  i_ex_mem,
    input  logic     i_ex_mem_valid,
    input  lc3b_word i_dmem_rdata,
    output lc3b_word o_dmem_addr,
    output lc3b_word o_dmem_wdata,
    output logic     o_dmem_read,
    output logic     o_dmem_write,
    output logic     o_mem_we,
    output lc3b_reg  o_mem_dest,
    output lc3b_word o_mem_result,
    output logic     o_wb_we,
    output lc3b_reg  o_wb_dest,
    output lc3b_word o_wb_data
);

    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb;
    logic    wb_valid;

    assign o_dmem_addr  = i_ex_mem.alu_result;
    assign o_dmem_wdata = i_ex_mem.store_data;
    assign o_dmem_read  = i_ex_mem_valid & i_ex_mem.d_mem_read;
    assign o_dmem_write = i_ex_mem_valid & i_ex_mem.d_mem_write;

    // Load data arrives this cycle and is forwarded straight back
    assign o_mem_result = i_ex_mem.d_mem_read ? i_dmem_rdata : i_ex_mem.alu_result;
    assign o_mem_we     = i_ex_mem_valid & i_ex_mem.load_regfile;
    assign o_mem_dest   = i_ex_mem.dest;

    always_comb begin
        mem_wb_d.load_regfile = i_ex_mem.load_regfile;
        mem_wb_d.dest         = i_ex_mem.dest;
        mem_wb_d.result       = o_mem_result;
    end

    stage_reg #(.T(mem_wb_t)) u_mem_wb (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (i_ex_mem_valid),
        .i_data  (mem_wb_d),
        .o_valid (wb_valid),
        .o_data  (mem_wb)
    );

    assign o_wb_we   = wb_valid & mem_wb.load_regfile; // Regfile write port
    assign o_wb_dest = mem_wb.dest;
    assign o_wb_data = mem_wb.result;

endmodule

//--- src/lc3b_pipeline.sv
`timescale 1ns/1ps

module lc3b_pipeline import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    output lc3b_word o_imem_addr,
    output logic     o_imem_read,
    input  lc3b_word i_imem_rdata,
    output lc3b_word o_dmem_addr,
    output lc3b_word o_dmem_wdata,
    output logic     o_dmem_read,
    output logic     o_dmem_write,
    input  lc3b_word i_dmem_rdata,
    output logic     o_wb_valid,
    output lc3b_reg  o_wb_dest,
    output lc3b_word o_wb_data
);

    lc3b_word ir;
    logic     ir_valid;
    id_ex_t   id_ex;
    logic     id_ex_valid;
    ex_mem_t  ex_mem;
    logic     ex_mem_valid;
    logic     mem_we;      // Memory stage to execute forwarding
    lc3b_reg  mem_dest;
    lc3b_word mem_result;

    fetch_stage u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_imem_rdata (i_imem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_imem_read  (o_imem_read),
        .o_ir         (ir),
        .o_ir_valid   (ir_valid)
    );

    decode_stage u_decode (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_ir          (ir),
        .i_ir_valid    (ir_valid),
        .i_wb_we       (o_wb_valid),
        .i_wb_dest     (o_wb_dest),
        .i_wb_data     (o_wb_data),
        .o_id_ex       (id_ex),
        .o_id_ex_valid (id_ex_valid)
    );

    execute_stage u_execute (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_id_ex        (id_ex),
        .i_id_ex_valid  (id_ex_valid),
        .i_mem_we       (mem_we),
        .i_mem_dest     (mem_dest),
        .i_mem_result   (mem_result),
        .i_wb_we        (o_wb_valid),
        .i_wb_dest      (o_wb_dest),
        .i_wb_data      (o_wb_data),
        .o_ex_mem       (ex_mem),
        .o_ex_mem_valid (ex_mem_valid)
    );

    memory_stage u_memory (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_ex_mem       (ex_mem),
        .i_ex_mem_valid (ex_mem_valid),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_dmem_read    (o_dmem_read),
        .o_dmem_write   (o_dmem_write),
        .o_mem_we       (mem_we),
        .o_mem_dest     (mem_dest),
        .o_mem_result   (mem_result),
        .o_wb_we        (o_wb_valid),
        .o_wb_dest      (o_wb_dest),
        .o_wb_data      (o_wb_data)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS    = 20,
    parameter int RST_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_NS o_clk = ~o_clk; // 40 ns period
    end

    // Reset held over the first rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

//--- test/lc3b_assertions.sv
`timescale 1ns/1ps

module lc3b_assertions import lc3b_pkg::*; (
    input logic     i_clk,
    input logic     i_rst,
    input lc3b_word i_imem_addr,
    input logic     i_dmem_read,
    input logic     i_dmem_write,
    input logic     i_wb_valid
);

    // One data access per cycle at most
    a_no_rw_overlap: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_dmem_read && i_dmem_write))
        else $error("data memory read and write strobes high in the same cycle");

    // Pipeline comes out of reset empty
    a_quiet_after_reset: assert property (@(posedge i_clk)
        $fell(i_rst) |-> (!i_dmem_read && !i_dmem_write && !i_wb_valid))
        else $error("memory strobe or writeback active in the first cycle after reset");

    a_even_fetch: assert property (@(posedge i_clk) disable iff (i_rst)
        i_imem_addr[0] == 1'b0)
        else $error("instruction address is odd");

endmodule

bind lc3b_pipeline lc3b_assertions u_assertions (
    .i_clk        (clk),
    .i_rst        (i_rst),
    .i_imem_addr  (o_imem_addr),
    .i_dmem_read  (o_dmem_read),
    .i_dmem_write (o_dmem_write),
    .i_wb_valid   (o_wb_valid)
);

//--- test/tb_lc3b.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module tb_lc3b import lc3b_pkg::*; ();

    localparam int PROG_LEN    = 200;
    localparam int MEM_WORDS   = 32768;
    localparam int PC_CHECKS   = 8;
    localparam int RST_TIMEOUT = 50;
    localparam int RUN_TIMEOUT = 1000;
    localparam int NUM_TESTS   = 5;
    localparam int T_RESET     = 0;
    localparam int T_ALU       = 1;
    localparam int T_LOAD      = 2;
    localparam int T_STORE     = 3;
    localparam int T_BUBBLE    = 4;

    // Opcodes outside the executed subset
    localparam lc3b_opcode UNKEPT [10] = '{op_br, op_ldb, op_stb, op_jsr, op_rti,
                                           op_ldi, op_sti, op_jmp, op_lea, op_trap};

    logic     clk;
    logic     rst;
    lc3b_word imem_addr;
    logic     imem_read;
    lc3b_word imem_rdata;
    lc3b_word dmem_addr;
    lc3b_word dmem_wdata;
    logic     dmem_read;
    logic     dmem_write;
    lc3b_word dmem_rdata;
    logic     wb_valid;
    lc3b_reg  wb_dest;
    lc3b_word wb_data;

    lc3b_word imem [MEM_WORDS];
    lc3b_word dmem [MEM_WORDS];
    lc3b_word mem_model [MEM_WORDS]; // Model's own copy of data memory
    lc3b_word regs_model [`LC3B_NUM_REGS];

    lc3b_reg  exp_wb_dest [$];
    lc3b_word exp_wb_data [$];
    logic     exp_wb_load [$];
    lc3b_word exp_st_addr [$];
    lc3b_word exp_st_data [$];

    int    n_wb_exp;
    int    n_st_exp;
    int    n_ld_exp;
    int    wb_seen;
    int    st_seen;
    int    rd_seen;
    int    timeouts;
    string test_name [NUM_TESTS];
    int    test_checks [NUM_TESTS];
    int    test_errs [NUM_TESTS];

    tb_clock u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    lc3b_pipeline UUT (
        .clk          (clk),
        .i_rst        (rst),
        .o_imem_addr  (imem_addr),
        .o_imem_read  (imem_read),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_read  (dmem_read),
        .o_dmem_write (dmem_write),
        .i_dmem_rdata (dmem_rdata),
        .o_wb_valid   (wb_valid),
        .o_wb_dest    (wb_dest),
        .o_wb_data    (wb_data)
    );

    // Both memories answer within the cycle
    assign imem_rdata = imem[imem_addr[15:1]];
    assign dmem_rdata = dmem[dmem_addr[15:1]];

    function automatic lc3b_word random_instr();
        logic [31:0] r;
        int unsigned pick;
        lc3b_word    ir;
        r    = $urandom();
        pick = $urandom_range(99, 0);
        if (pick < 10) begin
            ir = {UNKEPT[pick[3:0]], r[11:0]}; // About one in ten is a bubble
        end else begin
            case (pick % 6)
                0: ir = {op_add, r[11:6], r[5], r[5] ? r[4:0] : {2'b00, r[2:0]}};
                1: ir = {op_and, r[11:6], r[5], r[5] ? r[4:0] : {2'b00, r[2:0]}};
                2: ir = {op_not, r[11:6], 6'h3f};
                3: ir = {op_shf, r[11:0]};
                4: ir = {op_ldr, r[11:0]};
                default: ir = {op_str, r[11:0]};
            endcase
        end
        return ir;
    endfunction

    task automatic load_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i[14:0]]      = '0; // BR without condition bits
            dmem[i[14:0]]      = lc3b_word'($urandom());
            mem_model[i[14:0]] = dmem[i[14:0]];
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i[14:0]] = random_instr();
        end
    endtask

    task automatic expect_wb(input lc3b_reg dest, input lc3b_word data, input logic is_load);
        regs_model[dest] = data;
        exp_wb_dest.push_back(dest);
        exp_wb_data.push_back(data);
        exp_wb_load.push_back(is_load);
        n_wb_exp++;
    endtask

    // In-order ISA execution of the whole program
    task automatic run_model();
        lc3b_word   ir;
        lc3b_word   a;
        lc3b_word   b;
        lc3b_word   res;
        lc3b_word   addr;
        logic [3:0] amt;
        for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
            regs_model[i[2:0]] = '0;
        end
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            ir   = imem[pc[14:0]];
            a    = regs_model[ir[8:6]];
            addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
            amt  = ir[3:0];
            case (ir[15:12])
                op_add, op_and: begin
                    b   = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs_model[ir[2:0]];
                    res = (ir[15:12] == op_add) ? a + b : a & b;
                    expect_wb(ir[11:9], res, 1'b0);
                end
                op_not: expect_wb(ir[11:9], ~a, 1'b0);
                op_shf: begin
                    if (!ir[4]) begin
                        res = a << amt;
                    end else if (!ir[5]) begin
                        res = a >> amt;
                    end else begin
                        res = (a >> amt) | (a[15] ? ~(16'hffff >> amt) : 16'h0000);
                    end
                    expect_wb(ir[11:9], res, 1'b0);
                end
                op_ldr: begin
                    expect_wb(ir[11:9], mem_model[addr[15:1]], 1'b1);
                    n_ld_exp++;
                end
                op_str: begin
                    b = regs_model[ir[11:9]];
                    mem_model[addr[15:1]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    n_st_exp++;
                end
                default: ; // No architectural effect
            endcase
        end
    endtask

    task automatic compare_pc(input int t, input lc3b_word exp_pc, input lc3b_word act_pc);
        test_checks[t]++;
        if (exp_pc !== act_pc) begin
            $display("MISMATCH %s: expected %h, actual %h", test_name[t], exp_pc, act_pc);
            test_errs[t]++;
        end
    endtask

    task automatic compare_flag(input int t, input string what, input logic exp_v,
                                input logic act_v);
        test_checks[t]++;
        if (exp_v !== act_v) begin
            $display("MISMATCH %s: expected %s=%b, actual %b", test_name[t],
                     what, exp_v, act_v);
            test_errs[t]++;
        end
    endtask

    task automatic compare_wb(input int t, input lc3b_reg exp_dest, input lc3b_word exp_data,
                              input lc3b_reg act_dest, input lc3b_word act_data);
        test_checks[t]++;
        if (exp_dest !== act_dest || exp_data !== act_data) begin
            $display("MISMATCH %s: expected r%0d=%h, actual r%0d=%h", test_name[t],
                     exp_dest, exp_data, act_dest, act_data);
            test_errs[t]++;
        end
    endtask

    task automatic compare_store(input int t, input lc3b_word exp_addr, input lc3b_word exp_data,
                                 input lc3b_word act_addr, input lc3b_word act_data);
        test_checks[t]++;
        if (exp_addr !== act_addr || exp_data !== act_data) begin
            $display("MISMATCH %s: expected [%h]=%h, actual [%h]=%h", test_name[t],
                     exp_addr, exp_data, act_addr, act_data);
            test_errs[t]++;
        end
    endtask

    task automatic compare_count(input int t, input string what, input int exp_n, input int act_n);
        test_checks[t]++;
        if (exp_n != act_n) begin
            $display("MISMATCH %s: expected %0d %s, actual %0d", test_name[t],
                     exp_n, what, act_n);
            test_errs[t]++;
        end
    endtask

    task automatic check_writeback();
        wb_seen++;
        if (exp_wb_dest.size() == 0) begin
            $display("ERROR %s: writeback to r%0d with none expected", test_name[T_BUBBLE],
                     wb_dest);
            test_errs[T_BUBBLE]++;
        end else begin
            compare_wb(exp_wb_load.pop_front() ? T_LOAD : T_ALU, exp_wb_dest.pop_front(),
                       exp_wb_data.pop_front(), wb_dest, wb_data);
        end
    endtask

    task automatic check_store();
        st_seen++;
        dmem[dmem_addr[15:1]] = dmem_wdata;
        if (exp_st_addr.size() == 0) begin
            $display("ERROR %s: store to %h with none expected", test_name[T_BUBBLE], dmem_addr);
            test_errs[T_BUBBLE]++;
        end else begin
            compare_store(T_STORE, exp_st_addr.pop_front(), exp_st_data.pop_front(),
                          dmem_addr, dmem_wdata);
        end
    endtask

    // Samples the DUT mid-cycle, where its outputs are settled
    task automatic next_cycle();
        @(negedge clk);
        if (rst === 1'b0) begin
            if (wb_valid === 1'b1) begin
                check_writeback();
            end
            if (dmem_write === 1'b1) begin
                check_store();
            end
            if (dmem_read === 1'b1) begin
                rd_seen++;
            end
        end
    endtask

    task automatic report_test(input int t);
        $display("%s %s: %0d checks, %0d errors", (test_errs[t] == 0) ? "PASS" : "FAIL",
                 test_name[t], test_checks[t], test_errs[t]);
    endtask

    initial begin
        int cycles;
        int n_fail;
        void'($urandom(32'h1303254f));
        test_name[T_RESET]  = "reset_pc";
        test_name[T_ALU]    = "alu_results";
        test_name[T_LOAD]   = "load_results";
        test_name[T_STORE]  = "stores";
        test_name[T_BUBBLE] = "bubbles";
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_checks[t] = 0;
            test_errs[t]   = 0;
        end
        n_wb_exp = 0;
        n_st_exp = 0;
        n_ld_exp = 0;
        wb_seen  = 0;
        st_seen  = 0;
        rd_seen  = 0;
        timeouts = 0;
        load_memories();
        run_model();

        cycles = 0;
        next_cycle();
        while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("ERROR: reset was never released");
            timeouts++;
        end

        // Fetch starts at the reset PC and steps one word per cycle
        for (int k = 0; k < PC_CHECKS; k++) begin
            compare_pc(T_RESET, `LC3B_RESET_PC + lc3b_word'(2 * k), imem_addr);
            compare_flag(T_RESET, "imem_read", 1'b1, imem_read);
            next_cycle();
        end
        report_test(T_RESET);

        // Run until the last program word has left the pipeline
        cycles = 0;
        while (imem_addr < lc3b_word'(2 * (PROG_LEN + 8)) && cycles < RUN_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (imem_addr < lc3b_word'(2 * (PROG_LEN + 8))) begin
            $display("ERROR: program did not run to its end within the time limit");
            timeouts++;
        end

        compare_count(T_BUBBLE, "writebacks", n_wb_exp, wb_seen);
        compare_count(T_BUBBLE, "stores", n_st_exp, st_seen);
        compare_count(T_BUBBLE, "loads", n_ld_exp, rd_seen);
        for (int t = T_ALU; t < NUM_TESTS; t++) begin
            report_test(t);
        end

        n_fail = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (test_errs[t] != 0) begin
                n_fail++;
            end
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d timeouts",
                 NUM_TESTS, NUM_TESTS - n_fail, n_fail, timeouts);
        if (n_fail == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/lc3b_pkg.sv
src/stage_reg.sv
src/fetch_stage.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/lc3b_pipeline.sv
test/tb_clock.sv
test/lc3b_assertions.sv
test/tb_lc3b.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_lc3b -o tb_lc3b_sim \
    && ./obj_dir/tb_lc3b_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
